// File: hdl/output_port_pkg.sv
`default_nettype none

package output_port_pkg;

    ////////////////////////////////////////
    // field widths
    ////////////////////////////////////////

    // leaf and port numbering of the fat tree
    localparam int leaf_bits = 6;
    localparam int port_bits = 4;

    // remote fifo address, also the credit width
    localparam int addr_bits = 7;

    // payload is two user words side by side
    localparam int user_bits = 32;
    localparam int payload_bits = 64;

    // whole packet on the network side
    localparam int packet_bits = 97;

    // bits left between the route and the address
    localparam int reserved_bits =
        packet_bits - 1 - leaf_bits - port_bits - addr_bits - payload_bits;

    // local queue depth
    localparam int fifo_depth = 1 << addr_bits;

    // statistics counters
    localparam int stat_bits = 64;

    ////////////////////////////////////////
    // credit constants
    ////////////////////////////////////////

    // credit handed back by one add pulse
    localparam int freespace_update_size = 64;
    // remote buffer assumed nearly empty out of reset
    localparam int credit_reset = (1 << addr_bits) - 1;

    ////////////////////////////////////////
    // bundles
    ////////////////////////////////////////

    // outgoing packet, msb first
    typedef struct packed {
        logic                     valid;
        logic [leaf_bits-1:0]     dst_leaf;
        logic [port_bits-1:0]     dst_port;
        logic [reserved_bits-1:0] reserved;
        logic [addr_bits-1:0]     fifo_addr;
        logic [payload_bits-1:0]  payload;
    } packet_t;

    // destination of every packet from this port
    typedef struct packed {
        logic [leaf_bits-1:0] dst_leaf;
        logic [port_bits-1:0] dst_port;
    } route_t;

    // free space commands from the configuration side
    typedef struct packed {
        logic                 update_freespace_en;
        logic [addr_bits-1:0] freespace;
        logic                 add_freespace_en;
    } credit_cmd_t;

    // destination address load
    typedef struct packed {
        logic                 update_fifo_addr_en;
        logic [addr_bits-1:0] fifo_addr;
    } addr_cmd_t;

endpackage

`default_nettype wire

// File: hdl/word_packer.sv
`timescale 1ns/1ns
`default_nettype none

module word_packer (
    input  logic                                 clk,
    input  logic                                 reset,
    // user stream
    input  logic                                 user_valid,
    input  logic [output_port_pkg::user_bits-1:0] user_data,
    // queue side
    input  logic                                 full,
    output logic                                 ack,
    output logic                                 push,
    output logic [output_port_pkg::payload_bits-1:0] push_data
);

    import output_port_pkg::*;

    ////////////////////////////////////////
    // user handshake
    ////////////////////////////////////////

    // accept whenever the queue has room
    logic accept;
    // high while waiting for the upper word
    logic upper_next;
    // first word of the pair parks here
    logic [user_bits-1:0] low_word;

    assign ack    = ~full;
    assign accept = user_valid & ack;

    ////////////////////////////////////////
    // pairing
    ////////////////////////////////////////

    // toggles on every accepted word
    always_ff @(posedge clk) begin
        if (reset) begin
            upper_next <= 1'b0;
        end else if (accept) begin
            upper_next <= ~upper_next;
        end
    end

    // hold the low half until its partner shows up
    always_ff @(posedge clk) begin
        if (accept && !upper_next) begin
            low_word <= user_data;
        end
    end

    // second word goes straight into the queue with the held one
    assign push      = accept & upper_next;
    assign push_data = {user_data, low_word};

endmodule

`default_nettype wire

// File: hdl/packet_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module packet_fifo (
    input  logic                                     clk,
    input  logic                                     reset,
    // write side
    input  logic                                     push,
    input  logic [output_port_pkg::payload_bits-1:0] push_data,
    // read side
    input  logic                                     pop,
    output logic [output_port_pkg::payload_bits-1:0] pop_data,
    // status
    output logic                                     full,
    output logic                                     empty
);

    import output_port_pkg::*;

    ////////////////////////////////////////
    // storage and pointers
    ////////////////////////////////////////

    logic [payload_bits-1:0] mem [fifo_depth];

    // extra msb tells full from empty
    logic [addr_bits:0] wr_ptr;
    logic [addr_bits:0] rd_ptr;
    logic [addr_bits:0] wr_next;
    logic [addr_bits:0] rd_next;

    // requests that actually take effect
    logic push_ok;
    logic pop_ok;

    assign push_ok = push & ~full;
    assign pop_ok  = pop & ~empty;

    // pointer values after this edge
    always_comb begin
        wr_next = wr_ptr;
        rd_next = rd_ptr;
        if (push_ok) begin
            wr_next = wr_ptr + 1'b1;
        end
        if (pop_ok) begin
            rd_next = rd_ptr + 1'b1;
        end
    end

    ////////////////////////////////////////
    // control state
    ////////////////////////////////////////

    // flags come from next pointers so they stay registered
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            full   <= 1'b0;
            empty  <= 1'b1;
        end else begin
            wr_ptr <= wr_next;
            rd_ptr <= rd_next;
            empty  <= (wr_next == rd_next);
            // same slot but one lap ahead
            full   <= (wr_next[addr_bits-1:0] == rd_next[addr_bits-1:0]) &&
                      (wr_next[addr_bits] != rd_next[addr_bits]);
        end
    end

    ////////////////////////////////////////
    // memory ports
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr[addr_bits-1:0]] <= push_data;
        end
        // registered read, data one cycle after pop
        if (pop_ok) begin
            pop_data <= mem[rd_ptr[addr_bits-1:0]];
        end
    end

endmodule

`default_nettype wire

// File: hdl/credit_counter.sv
`timescale 1ns/1ns
`default_nettype none

module credit_counter (
    input  logic                         clk,
    input  logic                         reset,
    // free space commands
    input  output_port_pkg::credit_cmd_t cmd,
    // one entry sent this cycle
    input  logic                         pop,
    output logic                         has_credit
);

    import output_port_pkg::*;

    ////////////////////////////////////////
    // remote free space
    ////////////////////////////////////////

    // slots left in the far end buffer
    logic [addr_bits-1:0] credit;
    // amount added by an add pulse
    logic [addr_bits-1:0] add_step;

    // a pop in the same cycle eats one of the returned slots
    always_comb begin
        if (pop) begin
            add_step = addr_bits'(freespace_update_size - 1);
        end else begin
            add_step = addr_bits'(freespace_update_size);
        end
    end

    // load beats add, add beats plain decrement
    always_ff @(posedge clk) begin
        if (reset) begin
            credit <= addr_bits'(credit_reset);
        end else if (cmd.update_freespace_en) begin
            credit <= cmd.freespace;
        end else if (cmd.add_freespace_en) begin
            credit <= credit + add_step;
        end else if (pop && credit != '0) begin
            credit <= credit - 1'b1;
        end
    end

    ////////////////////////////////////////
    // read permission
    ////////////////////////////////////////

    // any free slot lets one more packet go
    assign has_credit = (credit != '0);

endmodule

`default_nettype wire

// File: hdl/packet_former.sv
`timescale 1ns/1ns
`default_nettype none

module packet_former (
    input  logic                                     clk,
    input  logic                                     reset,
    // network slot for this cycle
    input  logic                                     grant,
    input  logic                                     has_credit,
    input  logic                                     empty,
    // configuration
    input  output_port_pkg::addr_cmd_t               addr_cmd,
    input  output_port_pkg::route_t                  route,
    input  logic                                     done_mode,
    // queue read port
    input  logic [output_port_pkg::payload_bits-1:0] pop_data,
    output logic                                     pop,
    // to the network
    output output_port_pkg::packet_t                 packet_out
);

    import output_port_pkg::*;

    ////////////////////////////////////////
    // read issue
    ////////////////////////////////////////

    // fifo data lands one cycle after pop
    logic slot_valid;
    // destination fifo address for the next packet
    logic [addr_bits-1:0] fifo_addr_q;

    // grant only counts if there is data and room far away
    assign pop = grant & has_credit & ~empty;

    always_ff @(posedge clk) begin
        if (reset) begin
            slot_valid <= 1'b0;
        end else begin
            slot_valid <= pop;
        end
    end

    ////////////////////////////////////////
    // destination address
    ////////////////////////////////////////

    // steps after each filled slot, wraps on its own width
    always_ff @(posedge clk) begin
        if (reset) begin
            fifo_addr_q <= '0;
        end else if (addr_cmd.update_fifo_addr_en) begin
            fifo_addr_q <= addr_cmd.fifo_addr;
        end else if (slot_valid) begin
            fifo_addr_q <= fifo_addr_q + 1'b1;
        end
    end

    ////////////////////////////////////////
    // packet assembly
    ////////////////////////////////////////

    // zero bus when idle; done mode drops the popped payload
    always_comb begin
        packet_out = '0;
        if (slot_valid && !done_mode) begin
            packet_out.valid     = 1'b1;
            packet_out.dst_leaf  = route.dst_leaf;
            packet_out.dst_port  = route.dst_port;
            packet_out.reserved  = '0;
            packet_out.fifo_addr = fifo_addr_q;
            packet_out.payload   = pop_data;
        end
    end

endmodule

`default_nettype wire

// File: hdl/port_stats.sv
`timescale 1ns/1ns
`default_nettype none

module port_stats (
    input  logic                                  clk,
    input  logic                                  reset,
    // queue status
    input  logic                                  full,
    input  logic                                  empty,
    input  logic                                  user_valid,
    input  logic                                  done_mode,
    // statistics
    output logic [output_port_pkg::stat_bits-1:0] full_cnt,
    output logic [output_port_pkg::stat_bits-1:0] empty_cnt,
    output logic                                  stall
);

    ////////////////////////////////////////
    // queue condition counters
    ////////////////////////////////////////

    // cycles spent with the queue full
    always_ff @(posedge clk) begin
        if (reset) begin
            full_cnt <= '0;
        end else if (full && !done_mode) begin
            full_cnt <= full_cnt + 1'b1;
        end
    end

    // cycles spent with nothing to send
    always_ff @(posedge clk) begin
        if (reset) begin
            empty_cnt <= '0;
        end else if (empty && !done_mode) begin
            empty_cnt <= empty_cnt + 1'b1;
        end
    end

    // user has a word but the queue holds it off
    assign stall = user_valid & full & ~done_mode;

endmodule

`default_nettype wire

// File: hdl/output_port.sv
`timescale 1ns/1ns
`default_nettype none

module output_port (
    input  logic                                  clk,
    input  logic                                  reset,
    // user side
    input  logic                                  user_valid,
    input  logic [output_port_pkg::user_bits-1:0] user_data,
    output logic                                  ack,
    // network side
    input  logic                                  grant,
    input  output_port_pkg::route_t               route,
    input  output_port_pkg::credit_cmd_t          credit_cmd,
    input  output_port_pkg::addr_cmd_t            addr_cmd,
    input  logic                                  done_mode,
    output output_port_pkg::packet_t              packet_out,
    // statistics
    output logic [output_port_pkg::stat_bits-1:0] full_cnt,
    output logic [output_port_pkg::stat_bits-1:0] empty_cnt,
    output logic                                  stall
);

    import output_port_pkg::*;

    // queue write and read paths
    logic                    push;
    logic [payload_bits-1:0] push_data;
    logic                    pop;
    logic [payload_bits-1:0] pop_data;
    // queue and credit status
    logic                    full;
    logic                    empty;
    logic                    has_credit;

    ////////////////////////////////////////
    // write side
    ////////////////////////////////////////

    word_packer u_packer (
        .clk        (clk),
        .reset      (reset),
        .user_valid (user_valid),
        .user_data  (user_data),
        .full       (full),
        .ack        (ack),
        .push       (push),
        .push_data  (push_data)
    );

    packet_fifo u_fifo (
        .clk       (clk),
        .reset     (reset),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .pop_data  (pop_data),
        .full      (full),
        .empty     (empty)
    );

    ////////////////////////////////////////
    // read side
    ////////////////////////////////////////

    credit_counter u_credit (
        .clk        (clk),
        .reset      (reset),
        .cmd        (credit_cmd),
        .pop        (pop),
        .has_credit (has_credit)
    );

    packet_former u_former (
        .clk        (clk),
        .reset      (reset),
        .grant      (grant),
        .has_credit (has_credit),
        .empty      (empty),
        .addr_cmd   (addr_cmd),
        .route      (route),
        .done_mode  (done_mode),
        .pop_data   (pop_data),
        .pop        (pop),
        .packet_out (packet_out)
    );

    // full and empty tallies plus stall flag
    port_stats u_stats (
        .clk        (clk),
        .reset      (reset),
        .full       (full),
        .empty      (empty),
        .user_valid (user_valid),
        .done_mode  (done_mode),
        .full_cnt   (full_cnt),
        .empty_cnt  (empty_cnt),
        .stall      (stall)
    );

endmodule

`default_nettype wire

// File: bench/output_port_assert.sv
`timescale 1ns/1ns
`default_nettype none

module output_port_assert (
    input logic                                  clk,
    input logic                                  reset,
    input logic                                  user_valid,
    input logic [output_port_pkg::user_bits-1:0] user_data,
    input logic                                  ack,
    input logic                                  grant,
    input output_port_pkg::route_t               route,
    input output_port_pkg::credit_cmd_t          credit_cmd,
    input output_port_pkg::addr_cmd_t            addr_cmd,
    input logic                                  done_mode,
    input output_port_pkg::packet_t              packet_out,
    input logic [output_port_pkg::stat_bits-1:0] full_cnt,
    input logic [output_port_pkg::stat_bits-1:0] empty_cnt,
    input logic                                  stall
);

    import output_port_pkg::*;

    // number of failed checks
    int fails = 0;

    ////////////////////////////////////////
    // scoreboard
    ////////////////////////////////////////

    // accepted user words, oldest first
    logic [user_bits-1:0] words [$];
    logic                 second_half;
    int                   pairs_done = 0;
    int                   pkts_seen = 0;
    // payloads still in the queue this cycle
    int                   pending;
    logic [payload_bits-1:0] exp_payload;
    // destination address the next packet should carry
    logic [addr_bits-1:0] next_addr;
    // remote free space rebuilt one cycle late once the pop shows up
    logic [addr_bits-1:0] credit_prev;
    credit_cmd_t          cmd_prev;
    logic [addr_bits-1:0] credit_now;

    // a packet seen now means its pop happened last cycle
    always_comb begin
        pending = pairs_done - pkts_seen - int'(packet_out.valid);
        exp_payload = '0;
        if (words.size() >= 2) begin
            exp_payload = {words[1], words[0]};
        end
    end

    // load wins, add returns 64 minus a same-cycle pop, else pop takes one
    always_comb begin
        credit_now = credit_prev;
        if (cmd_prev.update_freespace_en) begin
            credit_now = cmd_prev.freespace;
        end else if (cmd_prev.add_freespace_en) begin
            credit_now = credit_prev + addr_bits'(freespace_update_size) - packet_out.valid;
        end else if (packet_out.valid && credit_prev != '0) begin
            credit_now = credit_prev - 1'b1;
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            words.delete();
            second_half <= 1'b0;
            pairs_done  <= 0;
            pkts_seen   <= 0;
            next_addr   <= '0;
            credit_prev <= addr_bits'(credit_reset);
            cmd_prev    <= '0;
        end else begin
            if (packet_out.valid && words.size() >= 2) begin
                void'(words.pop_front());
                void'(words.pop_front());
            end
            if (packet_out.valid) begin
                pkts_seen <= pkts_seen + 1;
            end
            // pairs complete on every second accepted word
            if (user_valid && ack) begin
                words.push_back(user_data);
                second_half <= ~second_half;
                if (second_half) begin
                    pairs_done <= pairs_done + 1;
                end
            end
            if (addr_cmd.update_fifo_addr_en) begin
                next_addr <= addr_cmd.fifo_addr;
            end else if (packet_out.valid) begin
                next_addr <= next_addr + 1'b1;
            end
            credit_prev <= credit_now;
            cmd_prev    <= credit_cmd;
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    reset_state: assert property (@(posedge clk)
        reset |=> packet_out == '0 && ack && !stall && full_cnt == '0 && empty_cnt == '0)
        else begin
            fails++;
            $error("reset state: expected 0/1/0/0/0, actual %h/%b/%b/%0d/%0d",
                $sampled(packet_out), $sampled(ack), $sampled(stall),
                $sampled(full_cnt), $sampled(empty_cnt));
        end

    payload_match: assert property (@(posedge clk) disable iff (reset)
        packet_out.valid |-> packet_out.payload == exp_payload)
        else begin
            fails++;
            $error("payload: expected %h, actual %h",
                $sampled(exp_payload), $sampled(packet_out.payload));
        end

    // route, reserved field and destination address
    header_match: assert property (@(posedge clk) disable iff (reset)
        packet_out.valid |-> packet_out.dst_leaf == route.dst_leaf &&
            packet_out.dst_port == route.dst_port && packet_out.reserved == '0 &&
            packet_out.fifo_addr == next_addr)
        else begin
            fails++;
            $error("header: expected %h/%h/0/%0d, actual %h/%h/%h/%0d",
                $sampled(route.dst_leaf), $sampled(route.dst_port), $sampled(next_addr),
                $sampled(packet_out.dst_leaf), $sampled(packet_out.dst_port),
                $sampled(packet_out.reserved), $sampled(packet_out.fifo_addr));
        end

    // grant with queued data and credit gives a packet next cycle and nothing else does
    send_rule: assert property (@(posedge clk) disable iff (reset)
        !done_mode |-> packet_out.valid == $past(grant && pending != 0 && credit_now != '0))
        else begin
            fails++;
            $error("send: expected valid %b, actual %b",
                $past(grant && pending != 0 && credit_now != '0), $sampled(packet_out.valid));
        end

    ack_rule: assert property (@(posedge clk) disable iff (reset)
        !done_mode |-> ack == (pending != fifo_depth))
        else begin
            fails++;
            $error("ack: expected %b, actual %b", $sampled(pending != fifo_depth), $sampled(ack));
        end

    stall_rule: assert property (@(posedge clk) disable iff (reset)
        stall == (user_valid && !ack && !done_mode))
        else begin
            fails++;
            $error("stall: expected %b, actual %b",
                $sampled(user_valid && !ack && !done_mode), $sampled(stall));
        end

    full_count: assert property (@(posedge clk) disable iff (reset)
        !done_mode |=> full_cnt == $past(full_cnt) + $past(!ack))
        else begin
            fails++;
            $error("full_cnt: expected %0d, actual %0d",
                $past(full_cnt) + $past(!ack), $sampled(full_cnt));
        end

    empty_count: assert property (@(posedge clk) disable iff (reset)
        !done_mode |=> empty_cnt == $past(empty_cnt) + $past(pending == 0))
        else begin
            fails++;
            $error("empty_cnt: expected %0d, actual %0d",
                $past(empty_cnt) + $past(pending == 0), $sampled(empty_cnt));
        end

    // quiet network side and frozen counters in done mode
    done_hold: assert property (@(posedge clk) disable iff (reset)
        done_mode |-> packet_out == '0 ##1 ($stable(full_cnt) && $stable(empty_cnt)))
        else begin
            fails++;
            $error("done mode: packet_out %h, full_cnt %0d, empty_cnt %0d",
                $sampled(packet_out), $sampled(full_cnt), $sampled(empty_cnt));
        end

endmodule

`default_nettype wire

// File: bench/output_port_tb.sv
`timescale 1ns/1ns
`default_nettype none

module output_port_tb;

    import output_port_pkg::*;

    ////////////////////////////////////////
    // run length
    ////////////////////////////////////////

    // phase budgets in cycles
    localparam int reset_cycles  = 2;
    localparam int mixed_cycles  = 200;
    localparam int addr_cycles   = 60;
    localparam int credit_cycles = 80;
    localparam int fill_cycles   = 2 * fifo_depth + fifo_depth + 80;
    localparam int done_cycles   = 2 * fifo_depth + 60;
    // double the sum as margin
    localparam int cycle_limit = 2 * (reset_cycles + mixed_cycles + addr_cycles +
        credit_cycles + fill_cycles + done_cycles);

    logic                    clk = 1'b0;
    logic                    reset;
    logic                    user_valid;
    logic [user_bits-1:0]    user_data;
    logic                    ack;
    logic                    grant;
    route_t                  route;
    credit_cmd_t             credit_cmd;
    addr_cmd_t               addr_cmd;
    logic                    done_mode;
    packet_t                 packet_out;
    logic [stat_bits-1:0]    full_cnt;
    logic [stat_bits-1:0]    empty_cnt;
    logic                    stall;

    int cycles = 0;
    // 0 no grant, 1 grant held, 2 random grant
    int grant_mode;
    logic [31:0] data_state = 32'd81936;
    logic [31:0] grant_state = 32'd81936;

    output_port dut (.*);

    bind output_port output_port_assert u_check (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    ////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////

    always @(posedge clk) begin
        grant_state <= xorshift(grant_state);
        case (grant_mode)
            1: grant <= 1'b1;
            2: grant <= grant_state[3];
            default: grant <= 1'b0;
        endcase
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // user words held while ack is low with optional random gaps
    task automatic push_words(input int count, input logic gaps);
        int sent;
        sent = 0;
        while (sent < count) begin
            @(posedge clk);
            if (user_valid && ack) begin
                sent++;
            end
            if (!(user_valid && !ack)) begin
                data_state = xorshift(data_state);
                if (sent < count && !(gaps && data_state[1:0] == 2'b00)) begin
                    user_valid <= 1'b1;
                    user_data  <= data_state;
                end else begin
                    user_valid <= 1'b0;
                end
            end
        end
    endtask

    task automatic wait_packets(input int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            @(posedge clk);
            if (packet_out.valid) begin
                seen++;
            end
        end
    endtask

    task automatic pulse_credit(input logic load, input logic [addr_bits-1:0] value,
                                input logic add);
        @(posedge clk);
        credit_cmd <= credit_cmd_t'{load, value, add};
        @(posedge clk);
        credit_cmd <= '0;
    endtask

    task automatic load_fifo_addr(input logic [addr_bits-1:0] value);
        @(posedge clk);
        addr_cmd <= addr_cmd_t'{1'b1, value};
        @(posedge clk);
        addr_cmd <= '0;
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial begin
        reset      = 1'b1;
        user_valid = 1'b0;
        user_data  = '0;
        grant      = 1'b0;
        route      = '0;
        credit_cmd = '0;
        addr_cmd   = '0;
        done_mode  = 1'b0;
        grant_mode = 0;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
        wait_cycles(4);

        // mixed traffic under random grant
        route <= route_t'{6'd21, 4'd9};
        grant_mode <= 2;
        fork
            push_words(40, 1'b1);
            wait_packets(20);
        join

        // address load just below the wrap
        grant_mode <= 0;
        wait_cycles(4);
        load_fifo_addr(7'd125);
        route <= route_t'{6'd42, 4'd3};
        grant_mode <= 1;
        fork
            push_words(16, 1'b0);
            wait_packets(8);
        join

        // three credits only and then one add pulse
        grant_mode <= 0;
        pulse_credit(1'b1, 7'd3, 1'b0);
        push_words(12, 1'b0);
        grant_mode <= 1;
        wait_packets(3);
        wait_cycles(8);
        pulse_credit(1'b0, '0, 1'b1);
        wait_packets(3);

        // fill all 128 entries without grant and drain after the stall
        grant_mode <= 0;
        pulse_credit(1'b1, addr_bits'(credit_reset), 1'b0);
        fork
            push_words(2 * fifo_depth + 2, 1'b0);
            begin
                wait_cycles(2 * fifo_depth + 12);
                grant_mode <= 1;
                // credit runs dry two short of the drain
                wait_cycles(fifo_depth + 12);
                pulse_credit(1'b0, '0, 1'b1);
            end
            wait_packets(fifo_depth + 1);
        join

        // done mode swallows whatever gets popped
        done_mode <= 1'b1;
        push_words(8, 1'b1);
        wait_cycles(10);

        // full queue in done mode leaves full_cnt and stall alone
        grant_mode <= 0;
        push_words(2 * fifo_depth, 1'b0);
        user_valid <= 1'b1;
        wait_cycles(6);
        user_valid <= 1'b0;

        wait_cycles(2);
        $display("failed checks: %0d, timeouts: 0, cycles: %0d", dut.u_check.fails, cycles);
        if (dut.u_check.fails == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (cycles >= cycle_limit);
        $display("run did not finish within %0d cycles", cycle_limit);
        $display("failed checks: %0d, timeouts: 1, cycles: %0d", dut.u_check.fails, cycles);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
hdl/output_port_pkg.sv
hdl/word_packer.sv
hdl/packet_fifo.sv
hdl/credit_counter.sv
hdl/packet_former.sv
hdl/port_stats.sv
hdl/output_port.sv
bench/output_port_assert.sv
bench/output_port_tb.sv

// File: Bender.yml
package:
  name: output_port

sources:
  - files:
      - hdl/output_port_pkg.sv
      - hdl/word_packer.sv
      - hdl/packet_fifo.sv
      - hdl/credit_counter.sv
      - hdl/packet_former.sv
      - hdl/port_stats.sv
      - hdl/output_port.sv
  - target: simulation
    files:
      - bench/output_port_assert.sv
      - bench/output_port_tb.sv
